//--- logic/vc_pkg.sv
// ***************************************************************************
// shared widths and request formats for the victim cache.
// ***************************************************************************

package vc_pkg;

	// one line address per entry, no offset bits.
	localparam int TAG_W = 29;

	// a full line moves in one transfer.
	localparam int DATA_W = 64;

	localparam int VC_ENTRIES = 4;
	localparam int IDX_W = $clog2(VC_ENTRIES);

	typedef enum logic
	{
		VC_READ  = 1'b0,
		VC_WRITE = 1'b1
	} vc_op_e;

	// request from the first-level cache.
	// data only matters for writes.
	typedef struct packed
	{
		vc_op_e              op;
		logic [TAG_W-1:0]    tag;
		logic [DATA_W-1:0]   data;
	} vc_req_t;

	// request toward physical memory.
	typedef struct packed
	{
		logic                write;
		logic [TAG_W-1:0]    tag;
		logic [DATA_W-1:0]   data;
	} pmem_req_t;

endpackage : vc_pkg

//--- logic/l1_port.sv
module l1_port
(
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        l1_req,
	input  vc_pkg::vc_req_t             l1_payload,
	output logic                        l1_ack,
	output logic [vc_pkg::DATA_W-1:0]   l1_rdata,
	output logic                        mem_read,
	output logic                        mem_write,
	output logic [vc_pkg::TAG_W-1:0]    tag,
	output logic [vc_pkg::DATA_W-1:0]   wdata,
	input  logic                        mem_resp,
	input  logic                        miss_get,
	input  logic [vc_pkg::DATA_W-1:0]   hit_data,
	input  logic [vc_pkg::DATA_W-1:0]   pmem_data
);

	vc_pkg::vc_req_t req_q;
	logic            pending;
	logic            accept;

	// new request only once the previous ack is down and nothing is in flight.
	assign accept = l1_req && !l1_ack && !pending;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pending <= 1'b0;
			l1_ack <= 1'b0;
		end
		else
		begin
			if (accept)
				pending <= 1'b1;
			else if (mem_resp)
				pending <= 1'b0;

			// ack follows the response, then waits for req to drop.
			if (mem_resp)
				l1_ack <= 1'b1;
			else if (!l1_req)
				l1_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			req_q <= l1_payload;
		if (mem_resp)
			l1_rdata <= miss_get ? pmem_data : hit_data;
	end

	assign mem_read  = pending && (req_q.op == vc_pkg::VC_READ);
	assign mem_write = pending && (req_q.op == vc_pkg::VC_WRITE);
	assign tag       = req_q.tag;
	assign wdata     = req_q.data;

	a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(l1_ack) |-> l1_req);

endmodule : l1_port

//--- logic/victim_store.sv
module victim_store
(
	input  logic                                      clk,
	input  logic                                      arst_n,
	input  logic [vc_pkg::TAG_W-1:0]                  tag,
	input  logic [vc_pkg::DATA_W-1:0]                 wdata,
	input  logic                                      ld_cache,
	input  logic                                      ld_from_vic,
	output logic                                      tag_match,
	output logic                                      victim_valid,
	output logic [vc_pkg::DATA_W-1:0]                 hit_data,
	output logic [vc_pkg::TAG_W+vc_pkg::DATA_W-1:0]   victim_line
);

	logic [vc_pkg::TAG_W-1:0]       tags  [vc_pkg::VC_ENTRIES];
	logic [vc_pkg::DATA_W-1:0]      lines [vc_pkg::VC_ENTRIES];
	logic [vc_pkg::VC_ENTRIES-1:0]  valid;
	logic [vc_pkg::IDX_W-1:0]       ptr;
	logic [vc_pkg::IDX_W-1:0]       hit_idx;
	logic [vc_pkg::IDX_W-1:0]       ld_idx;

	// ***********************************************************************
	// parallel tag compare.
	// ***********************************************************************

	// at most one entry can match, so the last hit found is the only one.
	always_comb
	begin
		tag_match = 1'b0;
		hit_idx = '0;
		for (int i = 0; i < vc_pkg::VC_ENTRIES; i++)
		begin
			if (valid[i] && (tags[i] == tag))
			begin
				tag_match = 1'b1;
				hit_idx = i[vc_pkg::IDX_W-1:0];
			end
		end
	end

	// overwrite in place on a hit, otherwise fill the fifo slot.
	assign ld_idx = tag_match ? hit_idx : ptr;

	assign hit_data     = lines[hit_idx];
	assign victim_valid = valid[ptr];
	assign victim_line  = {tags[ptr], lines[ptr]};

	// ***********************************************************************
	// valid bits and replacement pointer.
	// ***********************************************************************

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid <= '0;
			ptr <= '0;
		end
		else
		begin
			if (ld_cache)
			begin
				valid[ld_idx] <= 1'b1;
				if (!tag_match)
					ptr <= ptr + 1'b1;
			end
			// line goes back up to the first level.
			if (ld_from_vic)
				valid[hit_idx] <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ld_cache)
		begin
			tags[ld_idx] <= tag;
			lines[ld_idx] <= wdata;
		end
	end

	// a write miss never duplicates a tag that is already held.
	for (genvar i = 0; i < vc_pkg::VC_ENTRIES; i++)
	begin : g_uniq
		for (genvar j = i + 1; j < vc_pkg::VC_ENTRIES; j++)
		begin : g_pair
			a_unique_tag: assert property (@(posedge clk) disable iff (!arst_n)
				!(valid[i] && valid[j] && (tags[i] == tags[j])));
		end
	end

endmodule : victim_store

//--- logic/victim_cache_control.sv
module victim_cache_control
(
	input  logic clk,
	input  logic arst_n,
	input  logic mem_read,
	input  logic mem_write,
	input  logic tag_match,
	input  logic victim_valid,
	input  logic pmem_resp,
	output logic ld_cache,
	output logic ld_from_vic,
	output logic mem_resp,
	output logic miss_get,
	output logic pmem_read,
	output logic pmem_write
);

	typedef enum logic [1:0]
	{
		idle_check,
		phys_mem_write,
		phys_mem_read
	} state_e;

	state_e state;
	state_e next_state;

	// ***********************************************************************
	// state outputs.
	// ***********************************************************************

	always_comb
	begin
		ld_cache = 1'b0;
		ld_from_vic = 1'b0;
		mem_resp = 1'b0;
		miss_get = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;

		case (state)
			idle_check:
			begin
				// write hit, or write miss into a free slot.
				if (mem_write && (tag_match || !victim_valid))
				begin
					ld_cache = 1'b1;
					mem_resp = 1'b1;
				end
				else if (mem_read && tag_match)
				begin
					ld_from_vic = 1'b1;
					mem_resp = 1'b1;
				end
			end
			phys_mem_write:
			begin
				pmem_write = 1'b1;
				// old line is out, the new one takes its slot.
				if (pmem_resp)
				begin
					ld_cache = 1'b1;
					mem_resp = 1'b1;
				end
			end
			phys_mem_read:
			begin
				pmem_read = 1'b1;
				miss_get = 1'b1;
				mem_resp = pmem_resp;
			end
			default:
			begin
				ld_cache = 1'b0;
			end
		endcase
	end

	always_comb
	begin
		next_state = state;
		case (state)
			idle_check:
			begin
				if (mem_write && !tag_match && victim_valid)
					next_state = phys_mem_write;
				else if (mem_read && !tag_match)
					next_state = phys_mem_read;
			end
			phys_mem_write, phys_mem_read:
			begin
				if (pmem_resp)
					next_state = idle_check;
			end
			default:
			begin
				next_state = idle_check;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= idle_check;
		else
			state <= next_state;
	end

	// a response always answers a request that l1_port still holds.
	a_resp_has_req: assert property (@(posedge clk) disable iff (!arst_n)
		mem_resp |-> mem_read || mem_write);

endmodule : victim_cache_control

//--- logic/pmem_port.sv
module pmem_port
(
	input  logic                                      clk,
	input  logic                                      arst_n,
	input  logic                                      pmem_read,
	input  logic                                      pmem_write,
	input  logic [vc_pkg::TAG_W+vc_pkg::DATA_W-1:0]   victim_line,
	input  logic [vc_pkg::TAG_W-1:0]                  tag,
	output logic                                      pmem_req,
	output vc_pkg::pmem_req_t                         pmem_payload,
	input  logic                                      pmem_ack,
	input  logic [vc_pkg::DATA_W-1:0]                 pmem_rdata,
	output logic                                      pmem_resp,
	output logic [vc_pkg::DATA_W-1:0]                 pmem_data
);

	// set between ack seen high and ack seen low.
	logic drain;
	logic start;

	assign start = (pmem_read || pmem_write) && !pmem_req && !drain;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pmem_req <= 1'b0;
			pmem_resp <= 1'b0;
			drain <= 1'b0;
		end
		else
		begin
			pmem_resp <= 1'b0;
			if (start)
				pmem_req <= 1'b1;
			else if (pmem_req && pmem_ack)
			begin
				pmem_req <= 1'b0;
				pmem_resp <= 1'b1;
				drain <= 1'b1;
			end
			else if (drain && !pmem_ack)
				drain <= 1'b0;
		end
	end

	// write-back takes the victim line, a fill takes the request tag.
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			pmem_payload.write <= pmem_write;
			pmem_payload.tag <= pmem_write ?
				victim_line[vc_pkg::TAG_W+vc_pkg::DATA_W-1:vc_pkg::DATA_W] : tag;
			pmem_payload.data <= pmem_write ? victim_line[vc_pkg::DATA_W-1:0] : '0;
		end
		if (pmem_req && pmem_ack)
			pmem_data <= pmem_rdata;
	end

	// the control keeps the same level up for the whole transfer.
	a_level_held: assert property (@(posedge clk) disable iff (!arst_n)
		pmem_req |-> (pmem_payload.write ? pmem_write : pmem_read));

endmodule : pmem_port

//--- logic/victim_cache.sv
module victim_cache
(
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        l1_req,
	input  vc_pkg::vc_req_t             l1_payload,
	output logic                        l1_ack,
	output logic [vc_pkg::DATA_W-1:0]   l1_rdata,
	output logic                        pmem_req,
	output vc_pkg::pmem_req_t           pmem_payload,
	input  logic                        pmem_ack,
	input  logic [vc_pkg::DATA_W-1:0]   pmem_rdata
);

	logic                                     mem_read;
	logic                                     mem_write;
	logic [vc_pkg::TAG_W-1:0]                 tag;
	logic [vc_pkg::DATA_W-1:0]                wdata;
	logic                                     mem_resp;
	logic                                     miss_get;
	logic [vc_pkg::DATA_W-1:0]                hit_data;
	logic [vc_pkg::DATA_W-1:0]                pmem_data;
	logic                                     tag_match;
	logic                                     victim_valid;
	logic [vc_pkg::TAG_W+vc_pkg::DATA_W-1:0]  victim_line;
	logic                                     ld_cache;
	logic                                     ld_from_vic;
	logic                                     pmem_read;
	logic                                     pmem_write;
	logic                                     pmem_resp;

	// ***********************************************************************
	// input side, core, output side.
	// ***********************************************************************

	l1_port l1_port_i
	(
		.clk(clk), .arst_n(arst_n),
		.l1_req(l1_req), .l1_payload(l1_payload),
		.l1_ack(l1_ack), .l1_rdata(l1_rdata),
		.mem_read(mem_read), .mem_write(mem_write),
		.tag(tag), .wdata(wdata),
		.mem_resp(mem_resp), .miss_get(miss_get),
		.hit_data(hit_data), .pmem_data(pmem_data)
	);

	victim_store victim_store_i
	(
		.clk(clk), .arst_n(arst_n),
		.tag(tag), .wdata(wdata),
		.ld_cache(ld_cache), .ld_from_vic(ld_from_vic),
		.tag_match(tag_match), .victim_valid(victim_valid),
		.hit_data(hit_data), .victim_line(victim_line)
	);

	victim_cache_control victim_cache_control_i
	(
		.clk(clk), .arst_n(arst_n),
		.mem_read(mem_read), .mem_write(mem_write),
		.tag_match(tag_match), .victim_valid(victim_valid),
		.pmem_resp(pmem_resp),
		.ld_cache(ld_cache), .ld_from_vic(ld_from_vic),
		.mem_resp(mem_resp), .miss_get(miss_get),
		.pmem_read(pmem_read), .pmem_write(pmem_write)
	);

	pmem_port pmem_port_i
	(
		.clk(clk), .arst_n(arst_n),
		.pmem_read(pmem_read), .pmem_write(pmem_write),
		.victim_line(victim_line), .tag(tag),
		.pmem_req(pmem_req), .pmem_payload(pmem_payload),
		.pmem_ack(pmem_ack), .pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp), .pmem_data(pmem_data)
	);

endmodule : victim_cache

//--- tests/pmem_model.sv
module pmem_model
(
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        pmem_req,
	input  vc_pkg::pmem_req_t           pmem_payload,
	output logic                        pmem_ack,
	output logic [vc_pkg::DATA_W-1:0]   pmem_rdata,
	output int                          wb_count
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [vc_pkg::DATA_W-1:0] mem [logic [vc_pkg::TAG_W-1:0]];
	logic                      busy;
	int                        delay;

	// a line never written reads back as its tag repeated.
	function automatic logic [63:0] tag_fill(input logic [28:0] t);
		return {t[5:0], t, t};
	endfunction

	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pmem_ack <= 1'b0;
			pmem_rdata <= '0;
			busy <= 1'b0;
			delay <= 0;
			wb_count <= 0;
		end
		else if (pmem_ack)
		begin
			if (!pmem_req)
				pmem_ack <= 1'b0;
		end
		else if (pmem_req && !busy)
		begin
			busy <= 1'b1;
			delay <= int'($urandom_range(4, 0));
		end
		else if (busy)
		begin
			if (delay == 0)
			begin
				busy <= 1'b0;
				pmem_ack <= 1'b1;
				if (pmem_payload.write)
				begin
					mem[pmem_payload.tag] = pmem_payload.data;
					wb_count <= wb_count + 1;
				end
				else if (mem.exists(pmem_payload.tag))
					pmem_rdata <= mem[pmem_payload.tag];
				else
					pmem_rdata <= tag_fill(pmem_payload.tag);
			end
			else
				delay <= delay - 1;
		end
	end

endmodule : pmem_model

//--- tests/vc_tb.sv
module vc_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_RANDOM = 40;
	localparam int N_REQ = 13 + N_RANDOM;

	logic                      clk = 1'b0;
	logic                      arst_n;
	logic                      l1_req;
	vc_pkg::vc_req_t           l1_payload;
	logic                      l1_ack;
	logic [63:0]               l1_rdata;
	logic                      pmem_req;
	vc_pkg::pmem_req_t         pmem_payload;
	logic                      pmem_ack;
	logic [63:0]               pmem_rdata;
	int                        wb_count;

	// reference model of the four entries.
	logic [28:0]               ref_tag [4];
	logic [63:0]               ref_data [4];
	logic [3:0]                ref_valid;
	logic [1:0]                ref_ptr;
	logic [63:0]               ref_mem [logic [28:0]];

	logic [63:0]               exp_rdata;
	logic                      exp_read;
	logic                      exp_fast;
	int                        exp_pmem;
	logic [28:0]               exp_wb_tag;
	logic [63:0]               exp_wb_data;

	int                        errors = 0;
	int                        wait_cyc;
	int                        pmem_cnt;
	logic                      l1_req_d;
	logic                      pmem_req_d;

	always #2 clk = ~clk;

	victim_cache victim_cache_i
	(
		.clk(clk), .arst_n(arst_n),
		.l1_req(l1_req), .l1_payload(l1_payload),
		.l1_ack(l1_ack), .l1_rdata(l1_rdata),
		.pmem_req(pmem_req), .pmem_payload(pmem_payload),
		.pmem_ack(pmem_ack), .pmem_rdata(pmem_rdata)
	);

	pmem_model pmem_model_i
	(
		.clk(clk), .arst_n(arst_n),
		.pmem_req(pmem_req), .pmem_payload(pmem_payload),
		.pmem_ack(pmem_ack), .pmem_rdata(pmem_rdata),
		.wb_count(wb_count)
	);

	task automatic flag_error(input string msg);
		errors++;
		$display("** Error [%0t] %s", $time, msg);
	endtask

	function automatic logic [63:0] expected_fill(input logic [28:0] t);
		return {t[5:0], t, t};
	endfunction

	// ***********************************************************************
	// observers for latency and memory traffic per request.
	// ***********************************************************************

	always @(posedge clk)
	begin
		l1_req_d <= l1_req;
		pmem_req_d <= pmem_req;
		if (!l1_req)
			wait_cyc <= 0;
		else if (!l1_ack)
			wait_cyc <= wait_cyc + 1;
		if (l1_req && !l1_req_d)
			pmem_cnt <= 0;
		else if (pmem_req && !pmem_req_d)
			pmem_cnt <= pmem_cnt + 1;
	end

	// ***********************************************************************
	// checks.
	// ***********************************************************************

	a_reset_idle: assert property (@(posedge clk) $rose(arst_n) |-> !l1_ack && !pmem_req)
		else flag_error("ack or pmem_req high after reset");
	a_rdata: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(l1_ack) && exp_read |-> l1_rdata == exp_rdata)
		else flag_error("wrong read data");
	a_hit_latency: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(l1_ack) && exp_fast |-> wait_cyc == 2)
		else flag_error("wrong latency on a request served without memory");
	a_pmem_count: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(l1_ack) |-> pmem_cnt == exp_pmem)
		else flag_error("wrong number of memory requests");
	a_wb_line: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(pmem_req) && pmem_payload.write |->
		pmem_payload.tag == exp_wb_tag && pmem_payload.data == exp_wb_data)
		else flag_error("wrong write-back line");
	a_l1_ack_drop: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(l1_ack) |-> !$past(l1_req))
		else flag_error("l1_ack fell before l1_req was seen low");
	a_pmem_req_rise: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(pmem_req) |-> !$past(pmem_ack))
		else flag_error("pmem_req rose before pmem_ack was seen low");
	a_pmem_req_drop: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(pmem_req) |-> pmem_ack)
		else flag_error("pmem_req fell before pmem_ack");

	// ***********************************************************************
	// stimulus.
	// ***********************************************************************

	// predict the result, then run one four-phase transfer.
	task automatic access(input logic wr, input logic [28:0] t, input logic [63:0] d);
		int hit;
		hit = -1;
		for (int i = 0; i < 4; i++)
			if (ref_valid[i] && ref_tag[i] == t)
				hit = i;
		exp_read = !wr;
		exp_pmem = 0;
		if (wr && hit >= 0)
			ref_data[hit] = d;
		else if (wr)
		begin
			if (ref_valid[ref_ptr])
			begin
				exp_wb_tag = ref_tag[ref_ptr];
				exp_wb_data = ref_data[ref_ptr];
				ref_mem[exp_wb_tag] = exp_wb_data;
				exp_pmem = 1;
			end
			ref_tag[ref_ptr] = t;
			ref_data[ref_ptr] = d;
			ref_valid[ref_ptr] = 1'b1;
			ref_ptr = ref_ptr + 2'd1;
		end
		else if (hit >= 0)
		begin
			exp_rdata = ref_data[hit];
			ref_valid[hit] = 1'b0;
		end
		else
		begin
			exp_rdata = ref_mem.exists(t) ? ref_mem[t] : expected_fill(t);
			exp_pmem = 1;
		end
		exp_fast = (exp_pmem == 0);

		@(posedge clk);
		l1_req <= 1'b1;
		l1_payload <= '{op: wr ? vc_pkg::VC_WRITE : vc_pkg::VC_READ, tag: t, data: d};
		@(posedge clk);
		while (!l1_ack)
			@(posedge clk);
		l1_req <= 1'b0;
		@(posedge clk);
		while (l1_ack)
			@(posedge clk);
	endtask

	initial
	begin
		repeat (N_REQ * 40) @(posedge clk);
		$display("watchdog expired before all requests completed");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(32'hc7f3_38ad));
		arst_n = 1'b0;
		l1_req = 1'b0;
		l1_payload = '0;
		ref_valid = '0;
		ref_ptr = '0;
		exp_read = 1'b0;
		exp_fast = 1'b0;
		exp_pmem = 0;
		exp_rdata = '0;
		exp_wb_tag = '0;
		exp_wb_data = '0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		access(1'b0, 29'h100, '0);
		access(1'b1, 29'h200, 64'hdead_beef_0000_0200);
		access(1'b0, 29'h200, '0);
		access(1'b0, 29'h200, '0);
		// fill every slot, then force the oldest line out.
		access(1'b1, 29'h301, 64'h1111_0000_0000_0301);
		access(1'b1, 29'h302, 64'h2222_0000_0000_0302);
		access(1'b1, 29'h303, 64'h3333_0000_0000_0303);
		access(1'b1, 29'h304, 64'h4444_0000_0000_0304);
		access(1'b1, 29'h305, 64'h5555_0000_0000_0305);
		access(1'b0, 29'h301, '0);
		access(1'b1, 29'h303, 64'h3333_ffff_0000_0303);
		access(1'b0, 29'h303, '0);
		access(1'b1, 29'h306, 64'h6666_0000_0000_0306);

		for (int n = 0; n < N_RANDOM; n++)
		begin
			access(1'($urandom_range(1, 0)), 29'(32'h400 + $urandom_range(7, 0)),
				{$urandom, $urandom});
			repeat ($urandom_range(3, 0)) @(posedge clk);
		end
		repeat (4) @(posedge clk);

		$display("errors: %0d, requests: %0d, write-backs: %0d", errors, N_REQ, wb_count);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule : vc_tb

//--- list.f
logic/vc_pkg.sv
logic/l1_port.sv
logic/victim_store.sv
logic/victim_cache_control.sv
logic/pmem_port.sv
logic/victim_cache.sv
tests/pmem_model.sv
tests/vc_tb.sv

//--- run.sh
#!/bin/sh
# build the victim cache testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module vc_tb -o vc_sim &&
out=$(./obj_dir/vc_sim) &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -q "TESTBENCH PASSED" &&
echo "run.sh: simulation reported success" ||
{ echo "run.sh: simulation did not report success"; exit 1; }
